/* build.f */
logic/mbxCyclePkg.sv
logic/mbxBufferPkg.sv
logic/cycleDecode.sv
logic/mbWordTracker.sv
logic/cacheToMbSequencer.sv
logic/memRequestIssue.sv
logic/mbxTop.sv
tb/mbxTop_sva.sv
tb/mbxTb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir obj_dir --top-module mbxTb -f build.f
	-./obj_dir/VmbxTb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* tb/mbxTb.sv */
// Testbench top that drives mbxTop with seeded random stimulus and checks it against a cycle model
module mbxTb;

  logic                    clk;
  logic                    reset;
  mbxCyclePkg::cycleCmd_t  cmd;
  mbxCyclePkg::wordMask_t  loadMask;
  logic                    mbWrRqClr;
  logic                    writebackStart;
  logic                    phaseChangeComing;
  logic                    mbCyc;
  logic                    inhFirstReq;
  mbxBufferPkg::memReq_t   req;
  mbxBufferPkg::mbStatus_t status;
  logic                    cacheToMbDone;

  integer seed = 32'h40a2;

  // Model state
  mbxCyclePkg::wordMask_t   mPending;
  logic                     mHold;
  mbxBufferPkg::decodeOut_t mDec;
  mbxBufferPkg::memReq_t    mReq;
  logic                     mWrOutEn;
  logic                     mT1;
  logic                     mT2;
  logic                     mT3;
  logic                     mT4;

  mbxTop dut0 (
    .clk               (clk),
    .reset             (reset),
    .cmd               (cmd),
    .loadMask          (loadMask),
    .mbWrRqClr         (mbWrRqClr),
    .writebackStart    (writebackStart),
    .phaseChangeComing (phaseChangeComing),
    .mbCyc             (mbCyc),
    .inhFirstReq       (inhFirstReq),
    .req               (req),
    .status            (status),
    .cacheToMbDone     (cacheToMbDone)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Index of the first set bit or 0 for an empty mask
  function automatic mbxCyclePkg::wordIdx_t firstSetBit(input mbxCyclePkg::wordMask_t mask);
    mbxCyclePkg::wordIdx_t idx;
    logic                  found;
    idx = '0;
    found = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (mask[i] && !found) begin
        idx = 2'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task automatic failRun();
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      failRun();
    end
  endtask

  //////////////////////////////////////////////////
  // Cycle model that reads inputs as the DUT samples them
  //////////////////////////////////////////////////
  always @(posedge clk) begin : refModel
    mbxCyclePkg::wordIdx_t sel;
    logic                  rdNonValid;
    logic                  wrInMb;
    logic                  oldT4;
    if (reset) begin
      mPending = '0;
      mHold = 1'b0;
      mDec = '0;
      mReq = '0;
      {mWrOutEn, mT1, mT2, mT3, mT4} = '0;
    end else begin
      // Second pipeline stage first since it takes the previous decode
      mReq.memRdRq = mDec.rdRq;
      mReq.memWrRq = mDec.wrRq | mT4;
      mReq.rqWords = mDec.rqWords;
      mReq.firstWord = firstSetBit(mDec.rqWords);
      mReq.mbReqIn = mHold & ~mbCyc & ~inhFirstReq;

      rdNonValid = (cmd.coreRdRq & ~cmd.oneWordRd) | cmd.pageRefill;
      wrInMb = cmd.cacheWrCyc | cmd.writebackCyc;
      for (int i = 0; i < 4; i++) begin
        mDec.rqWords[i] = (cmd.oneWordRd && int'(cmd.wordAdr) == i) ||
                          (wrInMb && mPending[i]) || (rdNonValid && !cmd.wdValid[i]);
      end
      mDec.rdRq = cmd.coreRdRq | cmd.oneWordRd | rdNonValid;
      mDec.wrRq = wrInMb & (|mPending);
      mHold = |mPending;

      oldT4 = mT4;
      mT4 = mT3;
      mT3 = mT2 & phaseChangeComing;
      mT2 = (mT1 & (|mPending)) | (mT2 & ~phaseChangeComing);
      mT1 = mWrOutEn | oldT4;
      mWrOutEn = writebackStart;

      // Pending last because everything above used the old mask
      sel = firstSetBit(mPending);
      mPending = mPending | loadMask;
      if (mbWrRqClr) begin
        mPending[sel] = 1'b0;
      end
    end
  end

  // Outputs compared at the falling edge where they are settled
  always @(negedge clk) begin
    if (!reset) begin
      checkValue("req.memRdRq", 32'(mReq.memRdRq), 32'(req.memRdRq));
      checkValue("req.memWrRq", 32'(mReq.memWrRq), 32'(req.memWrRq));
      checkValue("req.rqWords", 32'(mReq.rqWords), 32'(req.rqWords));
      checkValue("req.firstWord", 32'(mReq.firstWord), 32'(req.firstWord));
      checkValue("req.mbReqIn", 32'(mReq.mbReqIn), 32'(req.mbReqIn));
      checkValue("status.pending", 32'(mPending), 32'(status.pending));
      checkValue("status.mbSel", 32'(firstSetBit(mPending)), 32'(status.mbSel));
      checkValue("status.mbReqHold", 32'(mHold), 32'(status.mbReqHold));
      checkValue("cacheToMbDone", 32'(mT1 & ~(|mPending)), 32'(cacheToMbDone));
    end
  end

  //////////////////////////////////////////////////
  // Directed and random sequences
  //////////////////////////////////////////////////

  // Read command held one cycle with the request due two edges after it is driven
  task automatic readCheck(input logic oneWord);
    mbxCyclePkg::cycleCmd_t c;
    mbxCyclePkg::wordMask_t expWords;
    logic [31:0]            rnd;
    rnd = $random(seed);
    c = '0;
    c.wdValid = rnd[7:4];
    if (oneWord) begin
      c.oneWordRd = 1'b1;
      c.wordAdr = rnd[1:0];
      expWords = '0;
      expWords[rnd[1:0]] = 1'b1;
    end else begin
      c.coreRdRq = rnd[8];
      c.pageRefill = ~rnd[8];
      expWords = ~rnd[7:4];
    end
    @(posedge clk);
    cmd <= c;
    @(posedge clk);
    cmd <= '0;
    @(negedge clk);
    checkValue("req.memRdRq", 32'd0, 32'(req.memRdRq));
    @(negedge clk);
    checkValue("req.memRdRq", 32'd1, 32'(req.memRdRq));
    checkValue("req.rqWords", 32'(expWords), 32'(req.rqWords));
    checkValue("req.firstWord", 32'(firstSetBit(expWords)), 32'(req.firstWord));
  endtask

  task automatic randomTraffic(input int cycles);
    logic [31:0] rnd;
    repeat (cycles) begin
      rnd = $random(seed);
      @(posedge clk);
      cmd <= mbxCyclePkg::cycleCmd_t'(rnd[10:0]);
      loadMask <= rnd[14:11] & rnd[18:15];
      mbWrRqClr <= rnd[19];
      mbCyc <= rnd[20];
      inhFirstReq <= rnd[21];
      phaseChangeComing <= rnd[22];
    end
    @(posedge clk);
    cmd <= '0;
    loadMask <= '0;
    mbWrRqClr <= 1'b0;
    mbCyc <= 1'b0;
    inhFirstReq <= 1'b0;
  endtask

  // Each word is cleared as its pass reaches T4, so the next T1 sees it gone
  task automatic writebackRun();
    logic [31:0] rnd;
    logic        done;
    logic        clrNext;
    int          k;
    int          writes;
    int          waited;
    rnd = $random(seed);
    @(posedge clk);
    loadMask <= rnd[3:0];
    @(posedge clk);
    loadMask <= '0;
    @(negedge clk);
    k = $countones(mPending);
    @(posedge clk);
    writebackStart <= 1'b1;
    @(posedge clk);
    writebackStart <= 1'b0;
    writes = 0;
    waited = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (req.memWrRq) begin
        writes++;
      end
      done = cacheToMbDone;
      clrNext = mT3;
      rnd = $random(seed);
      waited++;
      if (waited > 400) begin
        $display("timeout: cacheToMbDone never came at time %0t", $time);
        failRun();
      end
      @(posedge clk);
      mbWrRqClr <= clrNext;
      phaseChangeComing <= rnd[0];
    end
    mbWrRqClr <= 1'b0;
    phaseChangeComing <= 1'b0;
    @(negedge clk);
    checkValue("memWrRq count", 32'(k), 32'(writes));
    checkValue("status.pending", 32'd0, 32'(status.pending));
  endtask

  initial begin
    reset <= 1'b1;
    cmd <= '0;
    loadMask <= '0;
    mbWrRqClr <= 1'b0;
    writebackStart <= 1'b0;
    phaseChangeComing <= 1'b0;
    mbCyc <= 1'b0;
    inhFirstReq <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("req", 32'd0, 32'(req));
    checkValue("status", 32'd0, 32'(status));
    checkValue("cacheToMbDone", 32'd0, 32'(cacheToMbDone));

    repeat (8) readCheck(1'b1);
    repeat (8) readCheck(1'b0);
    randomTraffic(400);
    repeat (6) writebackRun();
    randomTraffic(100);

    $display("all tests passed");
    $finish;
  end

endmodule

/* tb/mbxTop_sva.sv */
// Concurrent checks on the MBX top level, attached to every mbxTop instance through bind
module mbxTopChecks (
  input logic                    clk,
  input logic                    reset,
  input mbxBufferPkg::memReq_t   req,
  input mbxBufferPkg::mbStatus_t status,
  input logic                    cacheToMbDone
);

  // Selected word must be one of the pending ones
  selIsPending: assert property (@(posedge clk) disable iff (reset)
    (status.pending != '0) |-> status.pending[status.mbSel])
    else $error("mbSel points at a word that is not pending");

  // Done marks the end of a transfer for one cycle only
  doneIsPulse: assert property (@(posedge clk) disable iff (reset)
    cacheToMbDone |=> !cacheToMbDone)
    else $error("cacheToMbDone stayed high for two cycles");

  resetClears: assert property (@(posedge clk)
    reset |=> ((req == '0) && !cacheToMbDone))
    else $error("req or cacheToMbDone not cleared by reset");

endmodule

bind mbxTop mbxTopChecks checks0 (
  .clk           (clk),
  .reset         (reset),
  .req           (req),
  .status        (status),
  .cacheToMbDone (cacheToMbDone)
);

/* logic/mbxTop.sv */
// MBX memory-buffer control top, connects cycle decode, word tracker, writeback sequencer and issue
module mbxTop (
  input  logic                    clk,
  input  logic                    reset,
  input  mbxCyclePkg::cycleCmd_t  cmd,
  input  mbxCyclePkg::wordMask_t  loadMask,
  input  logic                    mbWrRqClr,
  input  logic                    writebackStart,
  input  logic                    phaseChangeComing,
  input  logic                    mbCyc,
  input  logic                    inhFirstReq,
  output mbxBufferPkg::memReq_t   req,
  output mbxBufferPkg::mbStatus_t status,
  output logic                    cacheToMbDone
);

  mbxBufferPkg::decodeOut_t dec;
  logic                     cacheToMbT4;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////
  cycleDecode cycleDecode0 (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .pending (status.pending),
    .dec     (dec)
  );

  memRequestIssue memRequestIssue0 (
    .clk         (clk),
    .reset       (reset),
    .dec         (dec),
    .cacheToMbT4 (cacheToMbT4),
    .mbReqHold   (status.mbReqHold),
    .mbCyc       (mbCyc),
    .inhFirstReq (inhFirstReq),
    .req         (req)
  );

  //////////////////////////////////////////////////
  // MB bookkeeping and writeback
  //////////////////////////////////////////////////
  mbWordTracker mbWordTracker0 (
    .clk       (clk),
    .reset     (reset),
    .loadMask  (loadMask),
    .mbWrRqClr (mbWrRqClr),
    .status    (status)
  );

  cacheToMbSequencer cacheToMbSequencer0 (
    .clk               (clk),
    .reset             (reset),
    .writebackStart    (writebackStart),
    .phaseChangeComing (phaseChangeComing),
    .pending           (status.pending),
    .cacheToMbT4       (cacheToMbT4),
    .cacheToMbDone     (cacheToMbDone)
  );

endmodule

/* logic/memRequestIssue.sv */
// Memory request register stage, issues read and write requests, first word and the MB request
module memRequestIssue (
  input  logic                     clk,
  input  logic                     reset,
  input  mbxBufferPkg::decodeOut_t dec,
  input  logic                     cacheToMbT4,
  input  logic                     mbReqHold,
  input  logic                     mbCyc,
  input  logic                     inhFirstReq,
  output mbxBufferPkg::memReq_t    req
);

  mbxBufferPkg::memReq_t reqNext;

  //////////////////////////////////////////////////
  // Next request
  //////////////////////////////////////////////////
  always_comb begin
    reqNext.memRdRq = dec.rdRq;

    // Each writeback pass ends in a memory write
    reqNext.memWrRq = dec.wrRq | cacheToMbT4;

    reqNext.rqWords = dec.rqWords;

    // Memory starts the quad at the lowest wanted word
    reqNext.firstWord = mbxCyclePkg::lowestWord(dec.rqWords);

    // No MB request while the MB cycle runs or the first one is held off
    reqNext.mbReqIn = mbReqHold & ~mbCyc & ~inhFirstReq;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= '0;
    end else begin
      req <= reqNext;
    end
  end

endmodule

/* logic/cacheToMbSequencer.sv */
// Cache-to-MB writeback sequencer, steps T1..T4 once per word and flags the end of the transfer
module cacheToMbSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   writebackStart,
  input  logic                   phaseChangeComing,
  input  mbxCyclePkg::wordMask_t pending,
  output logic                   cacheToMbT4,
  output logic                   cacheToMbDone
);

  logic wrOutEn;
  logic t1;
  logic t2;
  logic t3;
  logic t4;
  logic moreWords;

  assign moreWords = |pending;

  // Nothing left at T1 ends the transfer
  assign cacheToMbDone = t1 & ~moreWords;

  //////////////////////////////////////////////////
  // Flip-flop chain, T1 re-entered from T4
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wrOutEn <= 1'b0;
      t1      <= 1'b0;
      t2      <= 1'b0;
      t3      <= 1'b0;
      t4      <= 1'b0;
    end else begin
      wrOutEn <= writebackStart;
      t1      <= wrOutEn | t4;
      // T2 waits here for the memory phase change
      t2      <= (t1 & moreWords) | (t2 & ~phaseChangeComing);
      t3      <= t2 & phaseChangeComing;
      t4      <= t3;
    end
  end

  assign cacheToMbT4 = t4;

endmodule

/* logic/mbWordTracker.sv */
// MB write-request tracker, keeps the pending word mask, picks the next word and forms the hold flag
module mbWordTracker (
  input  logic                    clk,
  input  logic                    reset,
  input  mbxCyclePkg::wordMask_t  loadMask,
  input  logic                    mbWrRqClr,
  output mbxBufferPkg::mbStatus_t status
);

  mbxCyclePkg::wordMask_t pending;
  mbxCyclePkg::wordMask_t pendingNext;
  mbxCyclePkg::wordMask_t clrMask;
  mbxCyclePkg::wordIdx_t  mbSel;
  logic                   mbReqHold;

  //////////////////////////////////////////////////
  // Word select
  //////////////////////////////////////////////////

  // Lowest pending word goes first
  assign mbSel = mbxCyclePkg::lowestWord(pending);

  // Decode the selected word for the clear strobe
  always_comb begin
    clrMask = '0;
    for (int i = 0; i < mbxCyclePkg::numWords; i++) begin
      if (mbSel == mbxCyclePkg::wordIdx_t'(i)) begin
        clrMask[i] = mbWrRqClr;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pending mask update
  //////////////////////////////////////////////////

  // New words are merged in first; a clear on the same word wins
  assign pendingNext = (pending | loadMask) & ~clrMask;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= pendingNext;
    end
  end

  // Hold follows the pending set one edge late
  always_ff @(posedge clk) begin
    if (reset) begin
      mbReqHold <= 1'b0;
    end else begin
      mbReqHold <= |pending;
    end
  end

  always_comb begin
    status.pending   = pending;
    status.mbSel     = mbSel;
    status.mbReqHold = mbReqHold;
  end

endmodule

/* logic/cycleDecode.sv */
// Cycle command decoder, turns the cache cycle levels into registered quad-word requests
module cycleDecode (
  input  logic                     clk,
  input  logic                     reset,
  input  mbxCyclePkg::cycleCmd_t   cmd,
  input  mbxCyclePkg::wordMask_t   pending,
  output mbxBufferPkg::decodeOut_t dec
);

  logic                     rdNonValWds;
  logic                     wrWdsInMb;
  mbxCyclePkg::wordMask_t   oneWordMask;
  mbxBufferPkg::decodeOut_t decNext;

  //////////////////////////////////////////////////
  // Cycle classes
  //////////////////////////////////////////////////

  // Reads that must fetch every word the cache does not hold
  assign rdNonValWds = (cmd.coreRdRq & ~cmd.oneWordRd) | cmd.pageRefill;

  // Cycles whose data sits in the MB waiting for memory
  assign wrWdsInMb = cmd.cacheWrCyc | cmd.writebackCyc;

  // One-hot word select for a single-word read
  always_comb begin
    oneWordMask = '0;
    for (int i = 0; i < mbxCyclePkg::numWords; i++) begin
      if (cmd.wordAdr == mbxCyclePkg::wordIdx_t'(i)) begin
        oneWordMask[i] = cmd.oneWordRd;
      end
    end
  end

  //////////////////////////////////////////////////
  // Word requests and request flags
  //////////////////////////////////////////////////
  always_comb begin
    decNext.rqWords = oneWordMask |
                      ({mbxCyclePkg::numWords{wrWdsInMb}} & pending) |
                      ({mbxCyclePkg::numWords{rdNonValWds}} & ~cmd.wdValid);

    // Any read class goes to memory as a read
    decNext.rdRq = cmd.coreRdRq | cmd.oneWordRd | rdNonValWds;

    // Writes only go out when the MB actually holds something
    decNext.wrRq = wrWdsInMb & (|pending);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec <= '0;
    end else begin
      dec <= decNext;
    end
  end

endmodule

/* logic/mbxBufferPkg.sv */
// Memory-buffer status and memory request types shared by the MBX tracker, issue logic and top
package mbxBufferPkg;

  //////////////////////////////////////////////////
  // MB write-request status
  //////////////////////////////////////////////////
  typedef struct packed {
    mbxCyclePkg::wordMask_t pending;   // Words still waiting to go to memory
    mbxCyclePkg::wordIdx_t  mbSel;     // Lowest pending word
    logic                   mbReqHold;
  } mbStatus_t;

  //////////////////////////////////////////////////
  // Registered requests toward the memory port
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                   memRdRq;
    logic                   memWrRq;
    mbxCyclePkg::wordMask_t rqWords;
    mbxCyclePkg::wordIdx_t  firstWord;
    logic                   mbReqIn;
  } memReq_t;

  // Decoded word requests, one stage before the memory request
  typedef struct packed {
    mbxCyclePkg::wordMask_t rqWords;
    logic                   rdRq;
    logic                   wrRq;
  } decodeOut_t;

endpackage

/* logic/mbxCyclePkg.sv */
// Cache cycle command types and quad-word helpers, referenced by scoped name from the MBX blocks
package mbxCyclePkg;

  // Words in one quad of the memory buffer
  localparam int numWords = 4;

  // Word index inside a quad, from the low physical address bits
  typedef logic [1:0] wordIdx_t;

  // One bit per quad word, bit 0 is word 0
  typedef logic [numWords-1:0] wordMask_t;

  //////////////////////////////////////////////////
  // Cache cycle levels, held for the whole cycle
  //////////////////////////////////////////////////
  typedef struct packed {
    logic      oneWordRd;
    logic      coreRdRq;
    logic      pageRefill;
    logic      cacheWrCyc;
    logic      writebackCyc;
    wordIdx_t  wordAdr;
    wordMask_t wdValid;     // Words already valid in the cache
  } cycleCmd_t;

  // Lowest-numbered set word of a mask, 0 when the mask is empty
  function automatic wordIdx_t lowestWord(input wordMask_t mask);
    wordIdx_t idx;
    idx = '0;
    // Scan from the top so the lowest set bit is the last one kept
    for (int i = numWords - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = wordIdx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage
